// ==== common/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath and address width
`define CPU_DBITS      32
`define CPU_REGNO_BITS 4
`define CPU_IMM_BITS   16

// Byte step between instructions
`define CPU_INST_SIZE  32'd4
`define CPU_START_PC   32'h0000_0100

`endif

// ==== common/cpu_pkg.sv ====
`include "cpu_defines.svh"

package cpu_pkg;

    // Primary opcode, bits 31..26
    typedef enum logic [5:0] {
        OP1_ALUR = 6'b000000,
        OP1_BEQ  = 6'b001000,
        OP1_BLT  = 6'b001001,
        OP1_BLE  = 6'b001010,
        OP1_BNE  = 6'b001011,
        OP1_JAL  = 6'b001100,
        OP1_SW   = 6'b011010,
        OP1_ADDI = 6'b100000,
        OP1_ANDI = 6'b100100,
        OP1_ORI  = 6'b100101,
        OP1_XORI = 6'b100110
    } op1_e;

    // Secondary opcode for the ALUR group, bits 25..18
    typedef enum logic [7:0] {
        OP2_EQ   = 8'b00001000,
        OP2_LT   = 8'b00001001,
        OP2_LE   = 8'b00001010,
        OP2_NE   = 8'b00001011,
        OP2_ADD  = 8'b00100000,
        OP2_AND  = 8'b00100100,
        OP2_OR   = 8'b00100101,
        OP2_XOR  = 8'b00100110,
        OP2_SUB  = 8'b00101000,
        OP2_NAND = 8'b00101100,
        OP2_NOR  = 8'b00101101,
        OP2_NXOR = 8'b00101110,
        OP2_RSHF = 8'b00110000,
        OP2_LSHF = 8'b00110001
    } op2_e;

    typedef enum logic [1:0] {
        ALU_SRC_RT   = 2'b00,
        ALU_SRC_IMM  = 2'b01,
        ALU_SRC_IMM4 = 2'b10   // Immediate times 4
    } alu_src_e;

    typedef enum logic {
        WB_SRC_PC  = 1'b0,     // Link address for JAL
        WB_SRC_ALU = 1'b1
    } wb_src_e;

    typedef struct packed {
        logic     reg_we;
        logic     mem_we;
        logic     is_branch;
        logic     is_jal;
        alu_src_e alu_src;
        wb_src_e  wb_src;
    } ctrl_t;

    typedef struct packed {
        logic [`CPU_DBITS-1:0] inst;
        logic [`CPU_DBITS-1:0] link_pc;
    } fetch_t;

    typedef struct packed {
        logic                      valid;
        logic [`CPU_DBITS-1:0]     link_pc;
        op1_e                      op1;
        op2_e                      op2;
        logic [`CPU_DBITS-1:0]     rs_val;
        logic [`CPU_DBITS-1:0]     rt_val;
        logic [`CPU_DBITS-1:0]     imm;      // Already sign extended
        logic [`CPU_REGNO_BITS-1:0] dst;
        ctrl_t                     ctrl;
    } id_ex_t;

    typedef struct packed {
        logic                      valid;
        logic                      reg_we;
        logic                      mem_we;
        wb_src_e                   wb_src;
        logic [`CPU_REGNO_BITS-1:0] dst;
        logic [`CPU_DBITS-1:0]     alu;
        logic [`CPU_DBITS-1:0]     st_data;
        logic [`CPU_DBITS-1:0]     link_pc;
    } ex_res_t;

    typedef struct packed {
        logic                      we;
        logic [`CPU_REGNO_BITS-1:0] regno;
        logic [`CPU_DBITS-1:0]     data;
    } wb_t;

    typedef struct packed {
        logic                  strobe;
        logic [`CPU_DBITS-1:0] addr;
        logic [`CPU_DBITS-1:0] data;
    } store_t;

endpackage

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  redirect,
    input  logic [`CPU_DBITS-1:0] target,
    output logic [`CPU_DBITS-1:0] imem_addr,
    input  logic [`CPU_DBITS-1:0] imem_data,
    output cpu_pkg::fetch_t       fetched,
    output logic                  fetched_valid
);

    logic [`CPU_DBITS-1:0] pc;
    logic [`CPU_DBITS-1:0] pc_plus;

    assign imem_addr = pc;   // ROM answers in the same cycle
    assign pc_plus   = pc + `CPU_INST_SIZE;

    // Redirect wins over stall, stall wins over advance
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc            <= `CPU_START_PC;
            fetched_valid <= 1'b0;
        end else if (redirect) begin
            pc            <= target;
            fetched_valid <= 1'b0;   // Flush the younger word
        end else if (!stall) begin
            pc            <= pc_plus;
            fetched_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!redirect && !stall) begin
            fetched.inst    <= imem_data;
            fetched.link_pc <= pc_plus;
        end
    end

endmodule

// ==== decode/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`CPU_REGNO_BITS-1:0] rs_addr,
    input  logic [`CPU_REGNO_BITS-1:0] rt_addr,
    output logic [`CPU_DBITS-1:0]      rs_val,
    output logic [`CPU_DBITS-1:0]      rt_val,
    input  cpu_pkg::wb_t               wb
);

    localparam int REG_WORDS = 1 << `CPU_REGNO_BITS;

    logic [`CPU_DBITS-1:0] regs [REG_WORDS];

    // r0 is never written
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REG_WORDS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && (wb.regno != '0)) begin
            regs[wb.regno] <= wb.data;
        end
    end

    // Write-through so decode sees the value in the write cycle
    function automatic logic [`CPU_DBITS-1:0] read_port(
        input logic [`CPU_REGNO_BITS-1:0] addr
    );
        if (addr == '0)
            return '0;
        else if (wb.we && (wb.regno == addr))
            return wb.data;
        else
            return regs[addr];
    endfunction

    always_comb rs_val = read_port(rs_addr);
    always_comb rt_val = read_port(rt_addr);

endmodule

// ==== decode/decode_stage.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decode_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  cpu_pkg::fetch_t            fetched,
    input  logic                       fetched_valid,
    input  logic                       redirect,
    input  logic [`CPU_REGNO_BITS-1:0] ex_dst,
    input  logic [`CPU_REGNO_BITS-1:0] res_dst,
    output logic [`CPU_REGNO_BITS-1:0] rs_addr,
    output logic [`CPU_REGNO_BITS-1:0] rt_addr,
    input  logic [`CPU_DBITS-1:0]      rs_val,
    input  logic [`CPU_DBITS-1:0]      rt_val,
    output logic                       stall,
    output cpu_pkg::id_ex_t            id_ex
);
    import cpu_pkg::*;

    op1_e                       op1;
    op2_e                       op2;
    logic [`CPU_IMM_BITS-1:0]   imm;
    logic [`CPU_DBITS-1:0]      imm_sxt;
    logic [`CPU_REGNO_BITS-1:0] rd;
    logic [`CPU_REGNO_BITS-1:0] rs;
    logic [`CPU_REGNO_BITS-1:0] rt;
    logic [`CPU_REGNO_BITS-1:0] dst;
    logic [`CPU_REGNO_BITS-1:0] id_dst;
    ctrl_t                      ctrl;
    logic                       uses_rt;
    logic                       rs_hit;
    logic                       rt_hit;

    // Instruction fields
    assign op1 = op1_e'(fetched.inst[31:26]);
    assign op2 = op2_e'(fetched.inst[25:18]);
    assign imm = fetched.inst[23:8];
    assign rd  = fetched.inst[11:8];
    assign rs  = fetched.inst[7:4];
    assign rt  = fetched.inst[3:0];

    assign imm_sxt = {{(`CPU_DBITS - `CPU_IMM_BITS){imm[`CPU_IMM_BITS-1]}}, imm};

    assign rs_addr = rs;
    assign rt_addr = rt;

    always_comb begin
        ctrl         = '0;
        ctrl.alu_src = ALU_SRC_IMM;
        ctrl.wb_src  = WB_SRC_ALU;
        uses_rt      = 1'b0;
        case (op1)
            OP1_ALUR: begin
                ctrl.reg_we  = 1'b1;
                ctrl.alu_src = ALU_SRC_RT;
                uses_rt      = 1'b1;
            end
            OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE: begin
                ctrl.is_branch = 1'b1;
                ctrl.alu_src   = ALU_SRC_RT;
                uses_rt        = 1'b1;
            end
            OP1_JAL: begin
                ctrl.reg_we  = 1'b1;
                ctrl.is_jal  = 1'b1;
                ctrl.alu_src = ALU_SRC_IMM4;   // rs + imm*4 is the jump target
                ctrl.wb_src  = WB_SRC_PC;
            end
            OP1_SW: begin
                ctrl.mem_we = 1'b1;
                uses_rt     = 1'b1;             // rt holds the store data
            end
            OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI: ctrl.reg_we = 1'b1;
            default: ;                          // Unknown opcode acts as a nop
        endcase
    end

    assign dst = (op1 == OP1_ALUR) ? rd : rt;

    // Producers without a register write show up as r0, which never matches
    assign id_dst = id_ex.ctrl.reg_we ? id_ex.dst : '0;

    assign rs_hit = (rs != '0) && ((rs == id_dst) || (rs == ex_dst) || (rs == res_dst));
    assign rt_hit = uses_rt && (rt != '0) &&
                    ((rt == id_dst) || (rt == ex_dst) || (rt == res_dst));
    assign stall  = fetched_valid && (rs_hit || rt_hit);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else if (stall || redirect || !fetched_valid) begin
            id_ex <= '0;   // Bubble
        end else begin
            id_ex.valid   <= 1'b1;
            id_ex.link_pc <= fetched.link_pc;
            id_ex.op1     <= op1;
            id_ex.op2     <= op2;
            id_ex.rs_val  <= rs_val;
            id_ex.rt_val  <= rt_val;
            id_ex.imm     <= imm_sxt;
            id_ex.dst     <= dst;
            id_ex.ctrl    <= ctrl;
        end
    end

endmodule

// ==== execute/execute_stage.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module execute_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  cpu_pkg::id_ex_t            id_ex,
    output logic                       redirect,
    output logic [`CPU_DBITS-1:0]      target,
    output cpu_pkg::ex_res_t           ex_res,
    output logic [`CPU_REGNO_BITS-1:0] ex_dst
);
    import cpu_pkg::*;

    localparam int DW = `CPU_DBITS;

    logic signed [DW-1:0] rs_s;
    logic signed [DW-1:0] rt_s;
    logic signed [DW-1:0] opnd;
    logic signed [DW-1:0] alu;
    logic [DW-1:0]        imm4;
    logic                 br_taken;

    assign rs_s = id_ex.rs_val;
    assign rt_s = id_ex.rt_val;
    assign imm4 = id_ex.imm << 2;

    always_comb begin
        case (id_ex.ctrl.alu_src)
            ALU_SRC_RT:   opnd = rt_s;
            ALU_SRC_IMM4: opnd = imm4;
            default:      opnd = id_ex.imm;
        endcase
    end

    // Comparisons are signed and yield 0 or 1
    always_comb begin
        alu = '0;
        case (id_ex.op1)
            OP1_ALUR: begin
                case (id_ex.op2)
                    OP2_EQ:   alu = {{(DW-1){1'b0}}, rs_s == opnd};
                    OP2_LT:   alu = {{(DW-1){1'b0}}, rs_s <  opnd};
                    OP2_LE:   alu = {{(DW-1){1'b0}}, rs_s <= opnd};
                    OP2_NE:   alu = {{(DW-1){1'b0}}, rs_s != opnd};
                    OP2_ADD:  alu = rs_s + opnd;
                    OP2_AND:  alu = rs_s & opnd;
                    OP2_OR:   alu = rs_s | opnd;
                    OP2_XOR:  alu = rs_s ^ opnd;
                    OP2_SUB:  alu = rs_s - opnd;
                    OP2_NAND: alu = ~(rs_s & opnd);
                    OP2_NOR:  alu = ~(rs_s | opnd);
                    OP2_NXOR: alu = ~(rs_s ^ opnd);
                    OP2_RSHF: alu = rs_s >>> opnd;   // Arithmetic
                    OP2_LSHF: alu = rs_s << opnd;
                    default:  alu = '0;
                endcase
            end
            OP1_ADDI, OP1_SW, OP1_JAL: alu = rs_s + opnd;   // SW address, JAL target
            OP1_ANDI: alu = rs_s & opnd;
            OP1_ORI:  alu = rs_s | opnd;
            OP1_XORI: alu = rs_s ^ opnd;
            default:  alu = '0;
        endcase
    end

    always_comb begin
        case (id_ex.op1)
            OP1_BEQ: br_taken = (rs_s == rt_s);
            OP1_BLT: br_taken = (rs_s <  rt_s);
            OP1_BLE: br_taken = (rs_s <= rt_s);
            OP1_BNE: br_taken = (rs_s != rt_s);
            default: br_taken = 1'b0;
        endcase
    end

    assign redirect = id_ex.valid && (id_ex.ctrl.is_jal || (id_ex.ctrl.is_branch && br_taken));
    assign target   = id_ex.ctrl.is_jal ? alu : id_ex.link_pc + imm4;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_res <= '0;
        end else if (redirect && !id_ex.ctrl.is_jal) begin
            ex_res <= '0;   // Taken branch leaves a bubble while JAL keeps its link write
        end else begin
            ex_res.valid   <= id_ex.valid;
            ex_res.reg_we  <= id_ex.ctrl.reg_we;
            ex_res.mem_we  <= id_ex.ctrl.mem_we;
            ex_res.wb_src  <= id_ex.ctrl.wb_src;
            ex_res.dst     <= id_ex.dst;
            ex_res.alu     <= alu;
            ex_res.st_data <= id_ex.rt_val;
            ex_res.link_pc <= id_ex.link_pc;
        end
    end

    // Seen by the decode interlock
    assign ex_dst = ex_res.reg_we ? ex_res.dst : '0;

endmodule

// ==== design/result_stage.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module result_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  cpu_pkg::ex_res_t           ex_res,
    output cpu_pkg::store_t            store,
    output cpu_pkg::wb_t               wb,
    output logic [`CPU_REGNO_BITS-1:0] res_dst
);
    import cpu_pkg::*;

    // Store goes out while the SW sits in the execute latch
    assign store.strobe = ex_res.valid && ex_res.mem_we;
    assign store.addr   = ex_res.alu;
    assign store.data   = ex_res.st_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.we    <= ex_res.valid && ex_res.reg_we;
            wb.regno <= ex_res.dst;
            wb.data  <= (ex_res.wb_src == WB_SRC_PC) ? ex_res.link_pc : ex_res.alu;
        end
    end

    // Last destination checked by the interlock
    assign res_dst = wb.we ? wb.regno : '0;

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_top (
    input  logic                  clk,
    input  logic                  reset,
    output logic [`CPU_DBITS-1:0] imem_addr,
    input  logic [`CPU_DBITS-1:0] imem_data,
    output cpu_pkg::store_t       store
);
    import cpu_pkg::*;

    fetch_t                     fetched;
    logic                       fetched_valid;
    logic                       stall;
    logic                       redirect;
    logic [`CPU_DBITS-1:0]      target;
    logic [`CPU_REGNO_BITS-1:0] rs_addr;
    logic [`CPU_REGNO_BITS-1:0] rt_addr;
    logic [`CPU_DBITS-1:0]      rs_val;
    logic [`CPU_DBITS-1:0]      rt_val;
    id_ex_t                     id_ex;
    ex_res_t                    ex_res;
    logic [`CPU_REGNO_BITS-1:0] ex_dst;
    logic [`CPU_REGNO_BITS-1:0] res_dst;
    wb_t                        wb;

    fetch_unit u_fetch (
        .clk(clk), .reset(reset), .stall(stall), .redirect(redirect), .target(target),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .fetched(fetched), .fetched_valid(fetched_valid)
    );

    decode_stage u_decode (
        .clk(clk), .reset(reset), .fetched(fetched), .fetched_valid(fetched_valid),
        .redirect(redirect), .ex_dst(ex_dst), .res_dst(res_dst),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_val(rs_val), .rt_val(rt_val),
        .stall(stall), .id_ex(id_ex)
    );

    reg_file u_regs (
        .clk(clk), .reset(reset), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .rs_val(rs_val), .rt_val(rt_val), .wb(wb)
    );

    execute_stage u_execute (
        .clk(clk), .reset(reset), .id_ex(id_ex), .redirect(redirect), .target(target),
        .ex_res(ex_res), .ex_dst(ex_dst)
    );

    result_stage u_result (
        .clk(clk), .reset(reset), .ex_res(ex_res), .store(store), .wb(wb), .res_dst(res_dst)
    );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;   // 50 % duty cycle
    end

endmodule

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int STIM_DEPTH      = 256;
    localparam int QUIET_CYCLES    = 20;
    localparam int CYCLES_PER_ITEM = 20;   // Watchdog budget per word and store

    logic                  clk;
    logic                  reset;
    logic [`CPU_DBITS-1:0] imem_addr;
    logic [`CPU_DBITS-1:0] imem_data;
    store_t                store;

    logic [31:0] stim [STIM_DEPTH];
    int          prog_len;
    int          store_cnt;
    int          store_idx;
    int          extra_stores;
    int          cycles_out;

    tb_clock #(.PERIOD_NS(10.0)) u_clock (.clk(clk));

    cpu_top u_dut (
        .clk(clk),
        .reset(reset),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .store(store)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    // JAL with rs = r0 and rt = r0 back onto its own address
    function automatic logic [31:0] halt_word(input logic [31:0] addr);
        return {6'b001100, 2'b00, addr[17:2], 8'h00};
    endfunction

    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `CPU_START_PC;
        if (addr >= `CPU_START_PC && addr[1:0] == 2'b00 && (offset >> 2) < prog_len)
            return stim[1 + (offset >> 2)];
        else
            return halt_word(addr);
    endfunction

    // Store groups in the order of the stimulus file
    function automatic string test_name(input int idx);
        if (idx < 14)
            return "alu_reg";
        else if (idx < 18)
            return "alu_imm";
        else if (idx < 20)
            return "interlock";
        else if (idx < 24)
            return "branch";
        else if (idx < 25)
            return "jal_link";
        else
            return "r0_write";
    endfunction

    task automatic check_store(input int idx, input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        exp_addr = stim[prog_len + 2 + 2 * idx];
        exp_data = stim[prog_len + 3 + 2 * idx];
        assert (addr == exp_addr)
            else abort_run($sformatf("[FAIL] %s store %0d address: expected %h, actual %h",
                                     test_name(idx), idx, exp_addr, addr));
        assert (data == exp_data)
            else abort_run($sformatf("[FAIL] %s store %0d data: expected %h, actual %h",
                                     test_name(idx), idx, exp_data, data));
    endtask

    // Address is stable since the rising edge
    always @(negedge clk) begin
        imem_data = rom_word(imem_addr);
    end

    always @(posedge clk) begin
        if (reset) begin
            cycles_out = 0;
            assert (store.strobe !== 1'b1)
                else abort_run("Store strobe seen while reset was held");
        end else begin
            cycles_out = cycles_out + 1;
            if (store.strobe) begin
                // Pipeline needs three edges before a store can reach the port
                assert (cycles_out > 3)
                    else abort_run("Store strobe on the first cycles after reset");
                if (store_idx < store_cnt) begin
                    check_store(store_idx, store.addr, store.data);
                    store_idx = store_idx + 1;
                end else begin
                    extra_stores = extra_stores + 1;
                end
            end
        end
    end

    initial begin
        reset        = 1'b1;
        imem_data    = '0;
        store_idx    = 0;
        extra_stores = 0;
        $readmemh("bench/cpu_stim.hex", stim);
        prog_len  = stim[0];
        store_cnt = stim[prog_len + 1];
        assert (prog_len > 0 && store_cnt > 0)
            else abort_run("Stimulus file is missing or holds no program or stores");

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // First fetch comes from the start address
        assert (imem_addr == 32'h0000_0100)
            else abort_run($sformatf("[FAIL] reset_pc fetch address: expected %h, actual %h",
                                     32'h0000_0100, imem_addr));

        while (store_idx < store_cnt) @(negedge clk);
        repeat (QUIET_CYCLES) @(negedge clk);   // Core should sit in its halt loop

        if (extra_stores == 0) begin
            $display("All %0d stores matched", store_cnt);
            $display("Regression passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d store(s) beyond the expected sequence", extra_stores));
        end
    end

    // Watchdog
    initial begin
        @(negedge reset);
        repeat ((prog_len + store_cnt) * CYCLES_PER_ITEM) @(posedge clk);
        abort_run($sformatf("Timeout with %0d of %0d stores seen", store_idx, store_cnt));
    end

endmodule

// ==== pipe_cpu.f ====
+incdir+common
common/cpu_pkg.sv
design/fetch_unit.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
design/result_stage.sv
design/cpu_top.sv
bench/tb_clock.sv
bench/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: pipe_cpu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - design/fetch_unit.sv
      - decode/reg_file.sv
      - decode/decode_stage.sv
      - execute/execute_stage.sv
      - design/result_stage.sv
      - design/cpu_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/tb_clock.sv
      - bench/cpu_tb.sv

// ==== bench/cpu_stim.hex ====
// Program word count, then instruction words from 0x100 on (several per line),
// then store count, then expected store address and data pairs in order
0000003F                            // 63 program words
80FF9C01 80000602                   // addi r1 = -100, addi r2 = 6
00200312 68004003                   // eq r3 = r1, r2 then sw r3 to 0x40
00240312 68004403                   // lt
00280312 68004803                   // le
002C0312 68004C03                   // ne
00800312 68005003                   // add
00900312 68005403                   // and
00940312 68005803                   // or
00980312 68005C03                   // xor
00A00312 68006003                   // sub
00B00312 68006403                   // nand
00B40312 68006803                   // nor
00B80312 68006C03                   // nxor
00C00312 68007003                   // rshf
00C40312 68007403                   // lshf
80005013 68007803                   // addi r3 = r1 + 80
90FFF013 68007C03                   // andi with 0xfff0
94002313 68008003                   // ori with 0x0023
98800113 68008403                   // xori with 0x8001
80000524 00800544 00A00652 68008806 // r4 = r2 + 5, r5 = r4 + r4, r6 = r5 - r2
80008C07 68000076                   // r7 = 0x8c, sw r6 through r7
20000222 6800F001 6800F001 68009002 // beq r2, r2 taken over two stores
2C000122 68009402                   // bne r2, r2 not taken
24000212 6800F001 6800F001 68009802 // blt r1, r2 taken
28000121 68009C02                   // ble r2, r1 not taken
80010009 30003C98 6800F001 6800F001 // r9 = 0x100, jal r8 to r9 + 0xf0
6800A008                            // sw link register r8
80005520 6800A400                   // write r0, then sw r0
0000001A                            // 26 stores
00000040 00000000 00000044 00000001
00000048 00000001 0000004C 00000001
00000050 FFFFFFA2 00000054 00000004
00000058 FFFFFF9E 0000005C FFFFFF9A
00000060 FFFFFF96 00000064 FFFFFFFB
00000068 00000061 0000006C 00000065
00000070 FFFFFFFE 00000074 FFFFE700
00000078 FFFFFFEC 0000007C FFFFFF90
00000080 FFFFFFBF 00000084 00007F9D
00000088 00000010 0000008C 00000010
00000090 00000006 00000094 00000006
00000098 00000006 0000009C 00000006
000000A0 000001E8 000000A4 00000000
